// File: cpu_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module cpu_decode (
	input  wire                 clk,
	input  wire                 i_rst,
	input  wire                 i_stall,
	input  wire                 i_flush,
	input  wire cpu_pkg::word_t i_instr,
	input  wire cpu_pkg::word_t i_pc_plus_4,
	input  wire                 i_valid,
	output cpu_pkg::reg_sel_t   o_ra_sel,
	output cpu_pkg::reg_sel_t   o_rb_sel,
	output cpu_pkg::reg_sel_t   o_rd_sel,
	output logic                o_wr_en,
	output cpu_pkg::alu_op_t    o_alu_op,
	output logic                o_op2_imm,
	output logic                o_load,
	output logic                o_store,
	output logic                o_branch,
	output cpu_pkg::word_t      o_imm32,
	output cpu_pkg::word_t      o_pc_plus_4,
	output logic                o_hold_fetch
);

	cpu_pkg::opcode_t  opc;
	cpu_pkg::reg_sel_t rd;
	cpu_pkg::reg_sel_t ra;
	cpu_pkg::reg_sel_t rb;
	cpu_pkg::imm_t     imm;
	cpu_pkg::reg_sel_t ra_q;
	cpu_pkg::reg_sel_t rb_q;
	cpu_pkg::alu_op_t  alu_op;
	cpu_pkg::word_t    imm32;
	logic              wr_en;
	logic              op2_imm;
	logic              load;
	logic              store;
	logic              branch;
	logic              uses_ra;
	logic              uses_rb;
	logic              hazard;

	assign opc = i_instr[`CPU_OPC_HI:`CPU_OPC_LO];
	assign rd = i_instr[`CPU_RD_HI:`CPU_RD_LO];
	assign ra = i_instr[`CPU_RA_HI:`CPU_RA_LO];
	assign rb = i_instr[`CPU_RB_HI:`CPU_RB_LO];
	assign imm = i_instr[`CPU_IMM_HI:`CPU_IMM_LO];

	// while stalled the register file keeps reading for the held instruction.
	assign o_ra_sel = i_stall ? ra_q : ra;
	assign o_rb_sel = i_stall ? rb_q : rb;

	always_comb begin
		alu_op = cpu_pkg::ALU_ADD;
		imm32 = {{16{imm[15]}}, imm};
		wr_en = 1'b0;
		op2_imm = 1'b0;
		load = 1'b0;
		store = 1'b0;
		branch = 1'b0;
		case (opc)
		cpu_pkg::OPC_ADD: wr_en = 1'b1;
		cpu_pkg::OPC_SUB: begin
			alu_op = cpu_pkg::ALU_SUB;
			wr_en = 1'b1;
		end
		cpu_pkg::OPC_AND: begin
			alu_op = cpu_pkg::ALU_AND;
			wr_en = 1'b1;
		end
		cpu_pkg::OPC_OR: begin
			alu_op = cpu_pkg::ALU_OR;
			wr_en = 1'b1;
		end
		cpu_pkg::OPC_XOR: begin
			alu_op = cpu_pkg::ALU_XOR;
			wr_en = 1'b1;
		end
		cpu_pkg::OPC_ADDI: begin
			wr_en = 1'b1;
			op2_imm = 1'b1;
		end
		cpu_pkg::OPC_LUI: begin
			alu_op = cpu_pkg::ALU_PASS;
			imm32 = {imm, 16'h0000};
			wr_en = 1'b1;
			op2_imm = 1'b1;
		end
		cpu_pkg::OPC_LDW: begin
			wr_en = 1'b1;
			op2_imm = 1'b1;
			load = 1'b1;
		end
		cpu_pkg::OPC_STW: begin
			op2_imm = 1'b1;
			store = 1'b1;
		end
		cpu_pkg::OPC_BEQ: branch = 1'b1;
		default: wr_en = 1'b0;
		endcase
	end

	// a load sitting in the decode/execute register has no data until writeback.
	assign uses_ra = (opc != cpu_pkg::OPC_LUI);
	assign uses_rb = !op2_imm || store;
	assign hazard = i_valid && o_load && o_wr_en &&
		((uses_ra && o_rd_sel == ra) || (uses_rb && o_rd_sel == rb));
	assign o_hold_fetch = hazard;

	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_wr_en <= 1'b0;
			o_load <= 1'b0;
			o_store <= 1'b0;
			o_branch <= 1'b0;
		end else if (!i_stall) begin
			if (i_flush || !i_valid || hazard) begin
				o_wr_en <= 1'b0;
				o_load <= 1'b0;
				o_store <= 1'b0;
				o_branch <= 1'b0;
			end else begin
				// r0 is never written, so it is never forwarded either.
				o_wr_en <= wr_en && (rd != '0);
				o_load <= load;
				o_store <= store;
				o_branch <= branch;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!i_stall) begin
			ra_q <= ra;
			rb_q <= rb;
			o_rd_sel <= rd;
			o_alu_op <= alu_op;
			o_op2_imm <= op2_imm;
			o_imm32 <= imm32;
			o_pc_plus_4 <= i_pc_plus_4;
		end
	end

endmodule

`default_nettype wire

// File: cpu_exec.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_exec (
	input  wire                    clk,
	input  wire                    i_rst,
	input  wire                    i_stall,
	input  wire cpu_pkg::reg_sel_t i_rd_sel,
	input  wire                    i_wr_en,
	input  wire cpu_pkg::alu_op_t  i_alu_op,
	input  wire                    i_op2_imm,
	input  wire                    i_load,
	input  wire                    i_store,
	input  wire                    i_branch,
	input  wire cpu_pkg::word_t    i_imm32,
	input  wire cpu_pkg::word_t    i_pc_plus_4,
	input  wire cpu_pkg::word_t    i_ra,
	input  wire cpu_pkg::word_t    i_rb,
	output logic                   o_branch_taken,
	output cpu_pkg::word_t         o_branch_target,
	output cpu_pkg::word_t         o_alu_out,
	output cpu_pkg::word_t         o_store_data,
	output cpu_pkg::reg_sel_t      o_rd_sel,
	output logic                   o_wr_en,
	output logic                   o_load,
	output logic                   o_store
);

	cpu_pkg::word_t op2;
	cpu_pkg::word_t result;

	assign op2 = i_op2_imm ? i_imm32 : i_rb;

	// loads and stores use the add path to form ra plus the offset.
	always_comb begin
		case (i_alu_op)
		cpu_pkg::ALU_ADD: result = i_ra + op2;
		cpu_pkg::ALU_SUB: result = i_ra - op2;
		cpu_pkg::ALU_AND: result = i_ra & op2;
		cpu_pkg::ALU_OR: result = i_ra | op2;
		cpu_pkg::ALU_XOR: result = i_ra ^ op2;
		cpu_pkg::ALU_PASS: result = op2;
		default: result = op2;
		endcase
	end

	// ************************************************************
	// branch resolution.
	// ************************************************************

	// the branch only fires in the cycle its instruction actually leaves execute.
	assign o_branch_taken = i_branch && (i_ra == i_rb) && !i_stall;
	assign o_branch_target = i_pc_plus_4 + {i_imm32[29:0], 2'b00};

	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_wr_en <= 1'b0;
			o_load <= 1'b0;
			o_store <= 1'b0;
		end else if (!i_stall) begin
			o_wr_en <= i_wr_en;
			o_load <= i_load;
			o_store <= i_store;
		end
	end

	always_ff @(posedge clk) begin
		if (!i_stall) begin
			o_alu_out <= result;
			o_store_data <= i_rb;
			o_rd_sel <= i_rd_sel;
		end
	end

endmodule

`default_nettype wire

// File: cpu_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module cpu_fetch (
	input  wire                 clk,
	input  wire                 i_rst,
	input  wire                 i_stall,
	input  wire                 i_branch_taken,
	input  wire cpu_pkg::word_t i_branch_target,
	input  wire cpu_pkg::word_t i_ibus_data,
	input  wire                 i_ibus_ack,
	output logic                o_ibus_access,
	output cpu_pkg::word_t      o_ibus_addr,
	output cpu_pkg::word_t      o_instr,
	output cpu_pkg::word_t      o_pc_plus_4,
	output logic                o_valid
);

	cpu_pkg::bus_state_t state;
	cpu_pkg::word_t      pc;
	cpu_pkg::word_t      next_pc;
	logic                stale;
	logic                ack_ok;
	logic                start;
	logic                buf_valid;
	cpu_pkg::word_t      buf_instr;
	cpu_pkg::word_t      buf_pc_plus_4;

	assign o_ibus_access = (state == cpu_pkg::WAIT);
	assign next_pc = i_branch_taken ? i_branch_target : pc;
	// a new fetch only goes out once the skid buffer is free.
	assign start = (state == cpu_pkg::IDLE) && !buf_valid;
	assign ack_ok = o_ibus_access && i_ibus_ack && !stale && !i_branch_taken;

	always_ff @(posedge clk) begin
		if (i_rst) begin
			state <= cpu_pkg::IDLE;
			pc <= `CPU_RESET_PC;
			stale <= 1'b0;
		end else if (start) begin
			state <= cpu_pkg::WAIT;
			pc <= next_pc + 32'd4;
		end else if (o_ibus_access) begin
			if (i_ibus_ack) begin
				state <= cpu_pkg::IDLE;
				stale <= 1'b0;
			end else if (i_branch_taken) begin
				stale <= 1'b1;
			end
			if (i_branch_taken)
				pc <= i_branch_target;
		end else if (i_branch_taken) begin
			pc <= i_branch_target;
		end
	end

	always_ff @(posedge clk) begin
		if (start)
			o_ibus_addr <= next_pc;
	end

	// ************************************************************
	// fetch/decode register with a one-entry skid buffer behind it.
	// ************************************************************
	always_ff @(posedge clk) begin
		if (i_rst || i_branch_taken) begin
			o_valid <= 1'b0;
			buf_valid <= 1'b0;
		end else if (!i_stall) begin
			o_valid <= buf_valid || ack_ok;
			buf_valid <= 1'b0;
		end else if (ack_ok) begin
			buf_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!i_stall) begin
			o_instr <= buf_valid ? buf_instr : i_ibus_data;
			o_pc_plus_4 <= buf_valid ? buf_pc_plus_4 : o_ibus_addr + 32'd4;
		end
		if (ack_ok) begin
			buf_instr <= i_ibus_data;
			buf_pc_plus_4 <= o_ibus_addr + 32'd4;
		end
	end

	a_ibus_hold: assert property (@(posedge clk) disable iff (i_rst)
		o_ibus_access && !i_ibus_ack |=> o_ibus_access && $stable(o_ibus_addr));

endmodule

`default_nettype wire

// File: cpu_memory.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_memory (
	input  wire                    clk,
	input  wire                    i_rst,
	input  wire cpu_pkg::word_t    i_alu_out,
	input  wire cpu_pkg::word_t    i_store_data,
	input  wire cpu_pkg::reg_sel_t i_rd_sel,
	input  wire                    i_wr_en,
	input  wire                    i_load,
	input  wire                    i_store,
	input  wire cpu_pkg::word_t    i_dbus_data,
	input  wire                    i_dbus_ack,
	output logic                   o_dbus_access,
	output cpu_pkg::word_t         o_dbus_addr,
	output logic                   o_dbus_wr_en,
	output cpu_pkg::word_t         o_dbus_wr_data,
	output logic                   o_stall,
	output cpu_pkg::reg_sel_t      o_rd_sel,
	output logic                   o_wr_en,
	output cpu_pkg::word_t         o_wr_val
);

	cpu_pkg::bus_state_t state;
	logic                mem_op;
	logic                done;

	assign mem_op = i_load || i_store;
	assign done = o_dbus_access && i_dbus_ack;

	// the execute/memory register is frozen during the access, so the
	// address and write data can come straight from it.
	assign o_dbus_access = (state == cpu_pkg::WAIT);
	assign o_dbus_addr = i_alu_out;
	assign o_dbus_wr_en = i_store;
	assign o_dbus_wr_data = i_store_data;
	assign o_stall = mem_op && !done;

	always_ff @(posedge clk) begin
		if (i_rst)
			state <= cpu_pkg::IDLE;
		else if (state == cpu_pkg::IDLE && mem_op)
			state <= cpu_pkg::WAIT;
		else if (done)
			state <= cpu_pkg::IDLE;
	end

	always_ff @(posedge clk) begin
		if (i_rst)
			o_wr_en <= 1'b0;
		else if (!o_stall)
			o_wr_en <= i_wr_en;
	end

	always_ff @(posedge clk) begin
		if (!o_stall) begin
			o_rd_sel <= i_rd_sel;
			o_wr_val <= i_load ? i_dbus_data : i_alu_out;
		end
	end

	a_dbus_hold: assert property (@(posedge clk) disable iff (i_rst)
		$fell(o_dbus_access) |-> $past(i_dbus_ack));

endmodule

`default_nettype wire

// File: cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// first instruction address after reset.
`define CPU_RESET_PC 32'h0000_0000

// size of the register file.
`define CPU_NUM_REGS 16

// instruction field positions.
`define CPU_OPC_HI 31
`define CPU_OPC_LO 28
`define CPU_RD_HI 27
`define CPU_RD_LO 24
`define CPU_RA_HI 23
`define CPU_RA_LO 20
`define CPU_RB_HI 19
`define CPU_RB_LO 16
`define CPU_IMM_HI 15
`define CPU_IMM_LO 0

`endif

// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0] reg_sel_t;
	typedef logic [15:0] imm_t;
	typedef logic [3:0] opcode_t;
	typedef logic [2:0] alu_op_t;

	// opcodes 10 to 15 decode as no-operations.
	localparam opcode_t OPC_ADD = 4'd0;
	localparam opcode_t OPC_SUB = 4'd1;
	localparam opcode_t OPC_AND = 4'd2;
	localparam opcode_t OPC_OR = 4'd3;
	localparam opcode_t OPC_XOR = 4'd4;
	localparam opcode_t OPC_ADDI = 4'd5;
	localparam opcode_t OPC_LUI = 4'd6;
	localparam opcode_t OPC_LDW = 4'd7;
	localparam opcode_t OPC_STW = 4'd8;
	localparam opcode_t OPC_BEQ = 4'd9;

	localparam alu_op_t ALU_ADD = 3'd0;
	localparam alu_op_t ALU_SUB = 3'd1;
	localparam alu_op_t ALU_AND = 3'd2;
	localparam alu_op_t ALU_OR = 3'd3;
	localparam alu_op_t ALU_XOR = 3'd4;
	localparam alu_op_t ALU_PASS = 3'd5;

	typedef enum logic {
		IDLE,
		WAIT
	} bus_state_t;

endpackage

`default_nettype wire

// File: cpu_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module cpu_regfile (
	input  wire                    clk,
	input  wire                    i_rst,
	input  wire cpu_pkg::reg_sel_t i_ra_sel,
	input  wire cpu_pkg::reg_sel_t i_rb_sel,
	input  wire cpu_pkg::reg_sel_t i_rd_sel,
	input  wire                    i_wr_en,
	input  wire cpu_pkg::word_t    i_wr_val,
	output cpu_pkg::word_t         o_ra,
	output cpu_pkg::word_t         o_rb
);

	cpu_pkg::word_t regs [`CPU_NUM_REGS];
	logic           wr_ok;

	assign wr_ok = i_wr_en && (i_rd_sel != '0);

	always_ff @(posedge clk) begin
		if (i_rst) begin
			for (int i = 0; i < `CPU_NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wr_ok) begin
			regs[i_rd_sel] <= i_wr_val;
		end
	end

	// a write in the same cycle goes straight through to the read port.
	always_ff @(posedge clk) begin
		o_ra <= (wr_ok && i_rd_sel == i_ra_sel) ? i_wr_val : regs[i_ra_sel];
		o_rb <= (wr_ok && i_rd_sel == i_rb_sel) ? i_wr_val : regs[i_rb_sel];
	end

	a_r0_ra: assert property (@(posedge clk) disable iff (i_rst)
		i_ra_sel == '0 |=> o_ra == '0);
	a_r0_rb: assert property (@(posedge clk) disable iff (i_rst)
		i_rb_sel == '0 |=> o_rb == '0);

endmodule

`default_nettype wire

// File: cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
	input  wire                 clk,
	input  wire                 i_rst,
	output wire                 o_ibus_access,
	output wire cpu_pkg::word_t o_ibus_addr,
	input  wire cpu_pkg::word_t i_ibus_data,
	input  wire                 i_ibus_ack,
	output wire                 o_dbus_access,
	output wire cpu_pkg::word_t o_dbus_addr,
	output wire                 o_dbus_wr_en,
	output wire cpu_pkg::word_t o_dbus_wr_data,
	input  wire cpu_pkg::word_t i_dbus_data,
	input  wire                 i_dbus_ack
);

	cpu_pkg::word_t    fd_instr;
	cpu_pkg::word_t    fd_pc_plus_4;
	logic              fd_valid;
	logic              f_stall;
	cpu_pkg::reg_sel_t d_ra_sel;
	cpu_pkg::reg_sel_t d_rb_sel;
	logic              d_hold_fetch;
	cpu_pkg::reg_sel_t de_rd_sel;
	logic              de_wr_en;
	cpu_pkg::alu_op_t  de_alu_op;
	logic              de_op2_imm;
	logic              de_load;
	logic              de_store;
	logic              de_branch;
	cpu_pkg::word_t    de_imm32;
	cpu_pkg::word_t    de_pc_plus_4;
	cpu_pkg::word_t    rf_ra;
	cpu_pkg::word_t    rf_rb;
	cpu_pkg::reg_sel_t e_ra_sel;
	cpu_pkg::reg_sel_t e_rb_sel;
	cpu_pkg::word_t    e_ra;
	cpu_pkg::word_t    e_rb;
	logic              ef_branch_taken;
	cpu_pkg::word_t    ef_branch_target;
	cpu_pkg::word_t    em_alu_out;
	cpu_pkg::word_t    em_store_data;
	cpu_pkg::reg_sel_t em_rd_sel;
	logic              em_wr_en;
	logic              em_load;
	logic              em_store;
	logic              m_stall;
	cpu_pkg::reg_sel_t mw_rd_sel;
	logic              mw_wr_en;
	cpu_pkg::word_t    mw_wr_val;

	// fetch also waits while decode inserts a load-use bubble.
	assign f_stall = m_stall || d_hold_fetch;

	cpu_fetch u_fetch (
		.clk(clk), .i_rst(i_rst), .i_stall(f_stall),
		.i_branch_taken(ef_branch_taken), .i_branch_target(ef_branch_target),
		.i_ibus_data(i_ibus_data), .i_ibus_ack(i_ibus_ack),
		.o_ibus_access(o_ibus_access), .o_ibus_addr(o_ibus_addr),
		.o_instr(fd_instr), .o_pc_plus_4(fd_pc_plus_4), .o_valid(fd_valid));

	cpu_decode u_decode (
		.clk(clk), .i_rst(i_rst), .i_stall(m_stall), .i_flush(ef_branch_taken),
		.i_instr(fd_instr), .i_pc_plus_4(fd_pc_plus_4), .i_valid(fd_valid),
		.o_ra_sel(d_ra_sel), .o_rb_sel(d_rb_sel), .o_rd_sel(de_rd_sel),
		.o_wr_en(de_wr_en), .o_alu_op(de_alu_op), .o_op2_imm(de_op2_imm),
		.o_load(de_load), .o_store(de_store), .o_branch(de_branch),
		.o_imm32(de_imm32), .o_pc_plus_4(de_pc_plus_4), .o_hold_fetch(d_hold_fetch));

	cpu_exec u_exec (
		.clk(clk), .i_rst(i_rst), .i_stall(m_stall),
		.i_rd_sel(de_rd_sel), .i_wr_en(de_wr_en), .i_alu_op(de_alu_op),
		.i_op2_imm(de_op2_imm), .i_load(de_load), .i_store(de_store),
		.i_branch(de_branch), .i_imm32(de_imm32), .i_pc_plus_4(de_pc_plus_4),
		.i_ra(e_ra), .i_rb(e_rb),
		.o_branch_taken(ef_branch_taken), .o_branch_target(ef_branch_target),
		.o_alu_out(em_alu_out), .o_store_data(em_store_data), .o_rd_sel(em_rd_sel),
		.o_wr_en(em_wr_en), .o_load(em_load), .o_store(em_store));

	cpu_memory u_memory (
		.clk(clk), .i_rst(i_rst),
		.i_alu_out(em_alu_out), .i_store_data(em_store_data), .i_rd_sel(em_rd_sel),
		.i_wr_en(em_wr_en), .i_load(em_load), .i_store(em_store),
		.i_dbus_data(i_dbus_data), .i_dbus_ack(i_dbus_ack),
		.o_dbus_access(o_dbus_access), .o_dbus_addr(o_dbus_addr),
		.o_dbus_wr_en(o_dbus_wr_en), .o_dbus_wr_data(o_dbus_wr_data),
		.o_stall(m_stall), .o_rd_sel(mw_rd_sel), .o_wr_en(mw_wr_en),
		.o_wr_val(mw_wr_val));

	cpu_regfile u_regfile (
		.clk(clk), .i_rst(i_rst),
		.i_ra_sel(d_ra_sel), .i_rb_sel(d_rb_sel),
		.i_rd_sel(mw_rd_sel), .i_wr_en(mw_wr_en), .i_wr_val(mw_wr_val),
		.o_ra(rf_ra), .o_rb(rf_rb));

	// ************************************************************
	// operand forwarding into execute.
	// ************************************************************

	// the selects line up with the registered register file outputs.
	always_ff @(posedge clk) begin
		e_ra_sel <= d_ra_sel;
		e_rb_sel <= d_rb_sel;
	end

	// the younger result in execute/memory wins over memory/writeback.
	always_comb begin
		if (em_wr_en && em_rd_sel == e_ra_sel)
			e_ra = em_alu_out;
		else if (mw_wr_en && mw_rd_sel == e_ra_sel)
			e_ra = mw_wr_val;
		else
			e_ra = rf_ra;

		if (em_wr_en && em_rd_sel == e_rb_sel)
			e_rb = em_alu_out;
		else if (mw_wr_en && mw_rd_sel == e_rb_sel)
			e_rb = mw_wr_val;
		else
			e_rb = rf_rb;
	end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
	verilator --binary --assert -f verilog.f --top-module tb_cpu -o tb_cpu &&
	./obj_dir/tb_cpu | tee /dev/stderr | grep -q "Testbench passed" &&
	echo "simulation ok" ||
	{ echo "simulation not ok"; exit 1; }

// File: tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

	logic           clk;
	logic           i_rst = 1'b1;
	logic           o_ibus_access;
	cpu_pkg::word_t o_ibus_addr;
	cpu_pkg::word_t i_ibus_data = '0;
	logic           i_ibus_ack = 1'b0;
	logic           o_dbus_access;
	cpu_pkg::word_t o_dbus_addr;
	logic           o_dbus_wr_en;
	cpu_pkg::word_t o_dbus_wr_data;
	cpu_pkg::word_t i_dbus_data = '0;
	logic           i_dbus_ack = 1'b0;

	cpu_pkg::word_t imem [64];
	cpu_pkg::word_t dmem [64];
	cpu_pkg::word_t exp_addr [32];
	cpu_pkg::word_t exp_data [32];
	logic [127:0]   exp_name [32];
	logic [6:0]     prog_len = '0;
	logic [5:0]     n_stores = '0;
	logic [5:0]     store_idx = '0;
	logic           loaded = 1'b0;
	logic           fetch_seen = 1'b0;
	logic           ibus_busy = 1'b0;
	logic           dbus_busy = 1'b0;
	cpu_pkg::word_t ibus_addr_q = '0;
	cpu_pkg::word_t dbus_addr_q = '0;
	int             ibus_cnt = 0;
	int             dbus_cnt = 0;
	int             value_errors = 0;
	int             protocol_errors = 0;
	int             input_errors = 0;
	int             cycles = 0;
	logic [15:0]    lfsr = 16'd46;

	cpu_top i_dut (
		.clk(clk), .i_rst(i_rst),
		.o_ibus_access(o_ibus_access), .o_ibus_addr(o_ibus_addr),
		.i_ibus_data(i_ibus_data), .i_ibus_ack(i_ibus_ack),
		.o_dbus_access(o_dbus_access), .o_dbus_addr(o_dbus_addr),
		.o_dbus_wr_en(o_dbus_wr_en), .o_dbus_wr_data(o_dbus_wr_data),
		.i_dbus_data(i_dbus_data), .i_dbus_ack(i_dbus_ack));

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	// two bits per draw give an ack delay of 1 to 4 cycles.
	task take_delay(output int d);
		logic [1:0] bits;
		bits[0] = lfsr[0];
		lfsr = lfsr_next(lfsr);
		bits[1] = lfsr[0];
		lfsr = lfsr_next(lfsr);
		d = {30'd0, bits} + 1;
	endtask

	task load_input;
		int              fd;
		int              got;
		int              fields;
		logic [7:0]      tag;
		cpu_pkg::word_t  val_a;
		cpu_pkg::word_t  val_b;
		logic [127:0]    name;
		logic [8*96-1:0] line;
		logic [6:0]      a;
		// unused words decode as no-operations that carry their own address.
		for (a = 7'd0; a < 7'd64; a = a + 7'd1)
			imem[a[5:0]] = {4'hf, 22'd0, a[5:0]};
		fd = $fopen("tb_input.txt", "r");
		if (fd == 0) begin
			input_errors++;
			$display("ERROR: cannot open tb_input.txt");
			return;
		end
		while (!$feof(fd)) begin
			line = '0;
			fields = 0;
			got = $fgets(line, fd);
			if (got > 0)
				fields = $sscanf(line, "%s %h %h %s", tag, val_a, val_b, name);
			if (fields >= 2 && tag == "P" && prog_len < 7'd64) begin
				imem[prog_len[5:0]] = val_a;
				prog_len = prog_len + 7'd1;
			end else if (fields >= 4 && tag == "S" && n_stores < 6'd32) begin
				exp_addr[n_stores[4:0]] = val_a;
				exp_data[n_stores[4:0]] = val_b;
				exp_name[n_stores[4:0]] = name;
				n_stores = n_stores + 6'd1;
			end
		end
		$fclose(fd);
		assert (prog_len != 7'd0 && n_stores != 6'd0) else begin
			input_errors++;
			$display("ERROR: tb_input.txt holds no program or no expected stores");
		end
	endtask

	task check_store(input cpu_pkg::word_t addr, input cpu_pkg::word_t data);
		assert (store_idx < n_stores) else begin
			protocol_errors++;
			$display("ERROR: store of %h to %h came after all expected stores", data, addr);
		end
		if (store_idx < n_stores) begin
			assert (addr == exp_addr[store_idx[4:0]]) else begin
				value_errors++;
				$display("FAIL %0s: address expected %h actual %h",
					exp_name[store_idx[4:0]], exp_addr[store_idx[4:0]], addr);
			end
			assert (data == exp_data[store_idx[4:0]]) else begin
				value_errors++;
				$display("FAIL %0s: data expected %h actual %h",
					exp_name[store_idx[4:0]], exp_data[store_idx[4:0]], data);
			end
			store_idx = store_idx + 6'd1;
		end
	endtask

	// ************************************************************
	// bus memory models.
	// ************************************************************

	task serve_ibus;
		if (i_ibus_ack) begin
			i_ibus_ack = 1'b0;
			ibus_busy = 1'b0;
		end else if (o_ibus_access && !ibus_busy) begin
			ibus_busy = 1'b1;
			ibus_addr_q = o_ibus_addr;
			take_delay(ibus_cnt);
			if (!fetch_seen) begin
				fetch_seen = 1'b1;
				assert (o_ibus_addr == 32'h0) else begin
					value_errors++;
					$display("FAIL reset_fetch: address expected %h actual %h", 32'h0, o_ibus_addr);
				end
				assert (!o_dbus_access) else begin
					protocol_errors++;
					$display("ERROR: data bus active before the first instruction fetch");
				end
			end
		end else if (o_ibus_access) begin
			assert (o_ibus_addr == ibus_addr_q) else begin
				protocol_errors++;
				$display("ERROR: instruction address changed while waiting for ack");
			end
			ibus_cnt = ibus_cnt - 1;
			if (ibus_cnt == 0) begin
				i_ibus_ack = 1'b1;
				i_ibus_data = imem[o_ibus_addr[7:2]];
			end
		end
	endtask

	task serve_dbus;
		if (i_dbus_ack) begin
			i_dbus_ack = 1'b0;
			dbus_busy = 1'b0;
		end else if (o_dbus_access && !dbus_busy) begin
			dbus_busy = 1'b1;
			dbus_addr_q = o_dbus_addr;
			take_delay(dbus_cnt);
		end else if (o_dbus_access) begin
			assert (o_dbus_addr == dbus_addr_q) else begin
				protocol_errors++;
				$display("ERROR: data address changed while waiting for ack");
			end
			dbus_cnt = dbus_cnt - 1;
			if (dbus_cnt == 0) begin
				i_dbus_ack = 1'b1;
				if (o_dbus_wr_en) begin
					check_store(o_dbus_addr, o_dbus_wr_data);
					dmem[o_dbus_addr[7:2]] = o_dbus_wr_data;
				end else begin
					i_dbus_data = dmem[o_dbus_addr[7:2]];
				end
			end
		end
	endtask

	task clear_data_memory;
		logic [6:0] a;
		for (a = 7'd0; a < 7'd64; a = a + 7'd1)
			dmem[a[5:0]] = '0;
	endtask

	always begin
		@(posedge clk);
		#1;
		cycles++;
		if (i_rst) begin
			assert (!o_ibus_access && !o_dbus_access) else begin
				protocol_errors++;
				$display("ERROR: bus access raised during reset");
			end
			clear_data_memory();
		end else begin
			serve_dbus();
			serve_ibus();
		end
		i_rst = (cycles < 8);
	end

	initial begin
		int limit;
		wait (loaded);
		limit = (int'(prog_len) + int'(n_stores) + 1) * 40;
		repeat (limit) @(posedge clk);
		$display("ERROR: timeout after %0d cycles with %0d of %0d stores seen",
			cycles, store_idx, n_stores);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		load_input();
		loaded = 1'b1;
		wait (store_idx == n_stores);
		// leave room for a stray store after the last expected one.
		repeat (40) @(posedge clk);
		$display("errors: %0d value, %0d protocol, %0d input; stores seen %0d of %0d",
			value_errors, protocol_errors, input_errors, store_idx, n_stores);
		if (value_errors == 0 && protocol_errors == 0 && input_errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb_input.txt
# P <instruction word> : loaded at consecutive word addresses from 0
# S <store address> <store data> <check name> : expected stores in program order
P 61001234 lui r1,0x1234
P 51105678 addi r1,r1,0x5678
P 520000ff addi r2,r0,0xff
P 23120000 and r3,r1,r2
P 44310000 xor r4,r3,r1
P 15420000 sub r5,r4,r2
P 36530000 or r6,r5,r3
P 07650000 add r7,r6,r5
P 80070040 stw [0x40],r7
P 78000040 ldw r8,[0x40]
P 09850000 add r9,r8,r5
P 80090044 stw [0x44],r9
P 50100007 addi r0,r1,7
P 80000048 stw [0x48],r0
P 90120002 beq r1,r2,+2
P 8003004c stw [0x4c],r3
P 80040050 stw [0x50],r4
P 90550002 beq r5,r5,+2
P 80010054 stw [0x54],r1
P 80020058 stw [0x58],r2
P 8006005c stw [0x5c],r6
P 9000ffff beq r0,r0,-1
S 00000040 2468aa7a alu_forwarding
S 00000044 369cff7b load_use
S 00000048 00000000 r0_write
S 0000004c 00000078 beq_untaken_a
S 00000050 12345600 beq_untaken_b
S 0000005c 12345579 beq_taken

// File: verilog.f
+incdir+.
cpu_pkg.sv
cpu_fetch.sv
cpu_decode.sv
cpu_exec.sv
cpu_memory.sv
cpu_regfile.sv
cpu_top.sv
tb_cpu.sv
